// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_scalar_unit
FILELIST  := sources.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(BIN) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sources.f
+incdir+test
src/scalar_pkg.sv
src/instr_store.sv
src/program_counter.sv
src/hazard_check.sv
src/reg_bank.sv
src/reg_file.sv
src/exec_unit.sv
src/scalar_unit.sv
test/tb_scalar_unit.sv

// File: src/exec_unit.sv
// Execution stage; ALU, status and condition registers, branch resolution and program end
`timescale 1ns/10ps

module exec_unit import scalar_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            run,
	input  exec_cmd_t       cmd,
	output wb_t             wb,
	output status_t         status,
	output logic            flag_busy,
	output logic            redirect,
	output logic [PC_W-1:0] target,
	output logic            halt,
	output logic            term
);

	opcode_e           op;
	cond_e             cond;
	logic [DATA_W-1:0] imm_ext;
	logic [DATA_W-1:0] result;
	logic              go;
	logic              cond_met;
	logic              taken;
	wb_t               wb_q;
	status_t           status_q;
	logic              taken_q;
	logic [PC_W-1:0]   target_q;
	logic              halt_q;
	logic              halted;

	////////////////////
	// Decode

	// Register view for the opcode, immediate view for operands and targets
	assign op      = cmd.instr.r.opcode;
	assign cond    = cond_e'(cmd.instr.i.dst[1:0]);
	assign imm_ext = {{(DATA_W-IMM_W){cmd.instr.i.imm[IMM_W-1]}}, cmd.instr.i.imm};

	// Nothing after HALT executes
	assign go        = cmd.valid & ~halted;
	assign flag_busy = go & op_sets_flags(op);

	always_comb begin
		case (op)
			OP_ADD:         result = cmd.op1 + cmd.op2;
			OP_SUB, OP_CMP: result = cmd.op1 - cmd.op2;
			OP_AND:         result = cmd.op1 & cmd.op2;
			OP_OR:          result = cmd.op1 | cmd.op2;
			OP_XOR:         result = cmd.op1 ^ cmd.op2;
			OP_ADDI:        result = cmd.op1 + imm_ext;
			OP_MOVI:        result = imm_ext;
			default:        result = '0;
		endcase
	end

	////////////////////
	// Branch resolution

	always_comb begin
		case (cond)
			COND_ZERO:     cond_met = status_q.zero;
			COND_NOT_ZERO: cond_met = ~status_q.zero;
			COND_NEG:      cond_met = status_q.neg;
			default:       cond_met = 1'b1;
		endcase
	end

	assign taken = go & ((op == OP_JMP) | ((op == OP_BRC) & cond_met));

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_q     <= '0;
			status_q <= '0;
			taken_q  <= 1'b0;
			halt_q   <= 1'b0;
			halted   <= 1'b0;
		end else if (run) begin
			wb_q.valid <= go & op_writes_reg(op);
			wb_q.dst   <= cmd.instr.r.dst;
			wb_q.data  <= result;
			if (flag_busy) begin
				status_q.zero <= (result == '0);
				status_q.neg  <= result[DATA_W-1];
			end
			taken_q <= taken;
			halt_q  <= go & (op == OP_HALT);
			halted  <= halted | (go & (op == OP_HALT));
		end
		if (run) begin
			target_q <= cmd.instr.i.imm[PC_W-1:0];
		end
	end

	// Pulses are held back while the unit is frozen
	always_comb begin
		wb       = wb_q;
		wb.valid = wb_q.valid & run;
	end

	assign status   = status_q;
	assign redirect = taken_q & run;
	assign target   = target_q;
	assign halt     = halt_q & run;
	assign term     = halt_q & run;

	a_no_wb_at_term: assert property (@(posedge clock) disable iff (reset)
		!(wb.valid && term));

endmodule

// File: src/hazard_check.sv
// Issue stage; holds fetched words against register and flag hazards, builds execution commands
`timescale 1ns/10ps

module hazard_check import scalar_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 run,
	input  logic                 fetch_valid,
	input  instr_u               fetch_instr,
	input  logic [PC_W-1:0]      fetch_addr,
	input  logic                 redirect,
	output logic [REG_IDX_W-1:0] rd_idx1,
	output logic [REG_IDX_W-1:0] rd_idx2,
	input  logic [DATA_W-1:0]    rd_data1,
	input  logic [DATA_W-1:0]    rd_data2,
	output exec_cmd_t            cmd,
	input  wb_t                  wb,
	input  logic                 flag_busy,
	output logic                 stall
);

	fetch_t    rs;
	exec_cmd_t cmd_q;
	opcode_e   rs_op;
	logic      exe_writes;
	logic      src1_hit;
	logic      src2_hit;
	logic      hazard;
	logic      issue;

	// Register index still owed by execution or write-back
	function automatic logic pending(logic [REG_IDX_W-1:0] idx);
		return (exe_writes && cmd.instr.r.dst == idx) || (wb.valid && wb.dst == idx);
	endfunction

	assign rs_op   = rs.instr.r.opcode;
	assign rd_idx1 = rs.instr.r.src1;
	assign rd_idx2 = rs.instr.r.src2;

	// Command being executed this cycle is dropped by a redirect
	always_comb begin
		cmd       = cmd_q;
		cmd.valid = cmd_q.valid & ~redirect;
	end

	assign exe_writes = cmd.valid & op_writes_reg(cmd.instr.r.opcode);
	assign src1_hit   = op_reads_src1(rs_op) & pending(rd_idx1);
	assign src2_hit   = op_reads_src2(rs_op) & pending(rd_idx2);
	assign hazard     = src1_hit | src2_hit | ((rs_op == OP_BRC) & flag_busy);

	assign stall = rs.valid & hazard & ~redirect;
	assign issue = rs.valid & ~hazard & ~redirect;

	always_ff @(posedge clock) begin
		if (reset) begin
			rs.valid    <= 1'b0;
			cmd_q.valid <= 1'b0;
		end else if (run) begin
			if (redirect || !stall) begin
				rs.valid <= fetch_valid & ~redirect;
			end
			cmd_q.valid <= issue;
		end
		if (run && !stall) begin
			rs.pc    <= fetch_addr;
			rs.instr <= fetch_instr;
		end
		if (run) begin
			cmd_q.pc    <= rs.pc;
			cmd_q.instr <= rs.instr;
			cmd_q.op1   <= rd_data1;
			cmd_q.op2   <= rd_data2;
		end
	end

endmodule

// File: src/instr_store.sv
// Instruction memory; written through the store port while halted, read by the fetch stage
`timescale 1ns/10ps

module instr_store import scalar_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          st_req,
	input  logic [$clog2(IMEM_DEPTH)-1:0] st_addr,
	input  instr_u                        st_instr,
	output logic                          st_ack,
	input  logic                          fetch_req,
	input  logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr,
	output instr_u                        fetch_instr
);

	instr_u mem [IMEM_DEPTH];

	// Ack follows the request by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			st_ack <= 1'b0;
		end else begin
			st_ack <= st_req;
		end
	end

	always_ff @(posedge clock) begin
		if (st_req) begin
			mem[st_addr] <= st_instr;
		end
		if (fetch_req) begin
			fetch_instr <= mem[fetch_addr];
		end
	end

	// Program loading and execution never overlap
	a_no_store_in_fetch: assert property (@(posedge clock) disable iff (reset)
		!(st_req && fetch_req));

endmodule

// File: src/program_counter.sv
// Program address control; steps the fetch address, takes branch targets and stops on halt
`timescale 1ns/10ps

module program_counter #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          run,
	input  logic                          stall,
	input  logic                          redirect,
	input  logic [$clog2(IMEM_DEPTH)-1:0] target,
	input  logic                          halt,
	output logic                          fetch_req,
	output logic [$clog2(IMEM_DEPTH)-1:0] fetch_addr
);

	localparam int ADDR_W = $clog2(IMEM_DEPTH);

	logic [ADDR_W-1:0] pc;
	logic              halted;

	// No fetch in the redirect cycle, the slot is discarded anyway
	assign fetch_req  = run & ~halted & ~stall & ~redirect;
	assign fetch_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (run) begin
			if (halt) begin
				halted <= 1'b1;
			end
			if (redirect) begin
				pc <= target;
			end else if (fetch_req) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// A single instruction either branches or ends the program
	a_redirect_halt_excl: assert property (@(posedge clock) disable iff (reset)
		!(redirect && halt));

endmodule

// File: src/reg_bank.sv
// One register bank, two asynchronous read ports and one write port; used for even and odd rows
`timescale 1ns/10ps

module reg_bank import scalar_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 we,
	input  logic [REG_IDX_W-2:0] waddr,
	input  logic [DATA_W-1:0]    wdata,
	input  logic [REG_IDX_W-2:0] raddr1,
	input  logic [REG_IDX_W-2:0] raddr2,
	output logic [DATA_W-1:0]    rdata1,
	output logic [DATA_W-1:0]    rdata2
);

	logic [DATA_W-1:0] rows [NUM_REGS/2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS/2; i++) begin
				rows[i] <= '0;
			end
		end else if (we) begin
			rows[waddr] <= wdata;
		end
	end

	assign rdata1 = rows[raddr1];
	assign rdata2 = rows[raddr2];

endmodule

// File: src/reg_file.sv
// Register file split into even and odd banks by the low index bit
`timescale 1ns/10ps

module reg_file import scalar_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [REG_IDX_W-1:0] rd_idx1,
	input  logic [REG_IDX_W-1:0] rd_idx2,
	output logic [DATA_W-1:0]    rd_data1,
	output logic [DATA_W-1:0]    rd_data2,
	input  wb_t                  wb
);

	logic [DATA_W-1:0] even1;
	logic [DATA_W-1:0] even2;
	logic [DATA_W-1:0] odd1;
	logic [DATA_W-1:0] odd2;

	// Both banks see both row addresses, low bit picks the result
	reg_bank even_bank (
		.clock  (clock),
		.reset  (reset),
		.we     (wb.valid & ~wb.dst[0]),
		.waddr  (wb.dst[REG_IDX_W-1:1]),
		.wdata  (wb.data),
		.raddr1 (rd_idx1[REG_IDX_W-1:1]),
		.raddr2 (rd_idx2[REG_IDX_W-1:1]),
		.rdata1 (even1),
		.rdata2 (even2)
	);

	reg_bank odd_bank (
		.clock  (clock),
		.reset  (reset),
		.we     (wb.valid & wb.dst[0]),
		.waddr  (wb.dst[REG_IDX_W-1:1]),
		.wdata  (wb.data),
		.raddr1 (rd_idx1[REG_IDX_W-1:1]),
		.raddr2 (rd_idx2[REG_IDX_W-1:1]),
		.rdata1 (odd1),
		.rdata2 (odd2)
	);

	assign rd_data1 = rd_idx1[0] ? odd1 : even1;
	assign rd_data2 = rd_idx2[0] ? odd2 : even2;

endmodule

// File: src/scalar_pkg.sv
// Shared widths, opcodes, instruction formats and pipeline records; imported by every RTL module
package scalar_pkg;

	localparam int DATA_W    = 32;
	localparam int NUM_REGS  = 16;
	localparam int REG_IDX_W = 4;
	localparam int INSTR_W   = 32;
	localparam int IMM_W     = 16;
	localparam int PC_W      = 6;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,
		OP_MOVI = 4'h7,
		OP_CMP  = 4'h8,
		OP_JMP  = 4'h9,
		OP_BRC  = 4'hA,
		OP_HALT = 4'hB
	} opcode_e;

	typedef enum logic [1:0] {
		COND_ALWAYS   = 2'd0,
		COND_ZERO     = 2'd1,
		COND_NOT_ZERO = 2'd2,
		COND_NEG      = 2'd3
	} cond_e;

	////////////////////
	// Instruction formats

	typedef struct packed {
		opcode_e               opcode;
		logic [REG_IDX_W-1:0]  dst;
		logic [REG_IDX_W-1:0]  src1;
		logic [REG_IDX_W-1:0]  src2;
		logic [15:0]           unused;
	} instr_reg_t;

	// For BRC the low two dst bits carry the condition
	typedef struct packed {
		opcode_e               opcode;
		logic [REG_IDX_W-1:0]  dst;
		logic [REG_IDX_W-1:0]  src1;
		logic [3:0]            spare;
		logic [IMM_W-1:0]      imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	////////////////////
	// Pipeline records

	typedef struct packed {
		logic             valid;
		logic [PC_W-1:0]  pc;
		instr_u           instr;
	} fetch_t;

	typedef struct packed {
		logic               valid;
		logic [PC_W-1:0]    pc;
		instr_u             instr;
		logic [DATA_W-1:0]  op1;
		logic [DATA_W-1:0]  op2;
	} exec_cmd_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_IDX_W-1:0]  dst;
		logic [DATA_W-1:0]     data;
	} wb_t;

	typedef struct packed {
		logic zero;
		logic neg;
	} status_t;

	////////////////////
	// Opcode classes

	function automatic logic op_writes_reg(opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MOVI};
	endfunction

	function automatic logic op_sets_flags(opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MOVI, OP_CMP};
	endfunction

	function automatic logic op_reads_src1(opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_CMP};
	endfunction

	function automatic logic op_reads_src2(opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_CMP};
	endfunction

endpackage

// File: src/scalar_unit.sv
// Top level of the scalar processor; connects fetch, issue, register file and execution
`timescale 1ns/10ps

module scalar_unit import scalar_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          run,
	input  logic                          st_req,
	input  logic [$clog2(IMEM_DEPTH)-1:0] st_addr,
	input  instr_u                        st_instr,
	output logic                          st_ack,
	output wb_t                           wb,
	output status_t                       status,
	output logic                          term
);

	localparam int ADDR_W = $clog2(IMEM_DEPTH);

	logic                 fetch_req;
	logic [ADDR_W-1:0]    fetch_addr;
	instr_u               fetch_instr;
	logic                 fetch_valid;
	logic [ADDR_W-1:0]    fetch_pc;
	logic                 stall;
	logic                 redirect;
	logic [PC_W-1:0]      target;
	logic                 halt;
	logic                 flag_busy;
	logic [REG_IDX_W-1:0] rd_idx1;
	logic [REG_IDX_W-1:0] rd_idx2;
	logic [DATA_W-1:0]    rd_data1;
	logic [DATA_W-1:0]    rd_data2;
	exec_cmd_t            cmd;

	program_counter #(.IMEM_DEPTH(IMEM_DEPTH)) i_program_counter (
		.clock, .reset, .run, .stall, .redirect, .target, .halt,
		.fetch_req, .fetch_addr
	);

	instr_store #(.IMEM_DEPTH(IMEM_DEPTH)) i_instr_store (
		.clock, .reset, .st_req, .st_addr, .st_instr, .st_ack,
		.fetch_req, .fetch_addr, .fetch_instr
	);

	// Fetch stage tag, follows the memory read by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid <= 1'b0;
		end else if (run && (redirect || !stall)) begin
			fetch_valid <= fetch_req;
		end
		if (fetch_req) begin
			fetch_pc <= fetch_addr;
		end
	end

	hazard_check i_hazard_check (
		.clock, .reset, .run, .fetch_valid, .fetch_instr,
		.fetch_addr (fetch_pc),
		.redirect, .rd_idx1, .rd_idx2, .rd_data1, .rd_data2,
		.cmd, .wb, .flag_busy, .stall
	);

	reg_file i_reg_file (
		.clock, .reset, .rd_idx1, .rd_idx2, .rd_data1, .rd_data2, .wb
	);

	exec_unit i_exec_unit (
		.clock, .reset, .run, .cmd, .wb, .status, .flag_busy,
		.redirect, .target, .halt, .term
	);

endmodule

// File: test/scalar_model.svh
// Instruction-level reference model; included by the testbench, runs the program image architecturally
`ifndef SCALAR_MODEL_SVH
`define SCALAR_MODEL_SVH

// Program image that the generator fills and the loader stores
logic [31:0] prog [IMEM_DEPTH];
int          prog_len;

// Expected write-back sequence and flags
logic [3:0]  exp_dst [$];
logic [31:0] exp_data [$];
logic        exp_zero;
logic        exp_neg;

function automatic logic [31:0] sign_extend(logic [15:0] imm);
	return {{16{imm[15]}}, imm};
endfunction

function automatic void model_execute();
	logic [31:0] regs [16];
	logic [31:0] word;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	opcode_e     op;
	logic        writes;
	logic        sets_flags;
	logic        jump;
	logic        done;
	int          pc;
	exp_dst.delete();
	exp_data.delete();
	exp_zero = 1'b0;
	exp_neg  = 1'b0;
	for (int r = 0; r < 16; r++) begin
		regs[r] = '0;
	end
	pc   = 0;
	done = 1'b0;
	while (!done && pc < prog_len) begin
		word       = prog[pc];
		op         = opcode_e'(word[31:28]);
		a          = regs[word[23:20]];
		b          = regs[word[19:16]];
		res        = '0;
		writes     = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MOVI};
		sets_flags = writes || (op == OP_CMP);
		jump       = 1'b0;
		case (op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = a + sign_extend(word[15:0]);
			OP_MOVI: res = sign_extend(word[15:0]);
			OP_CMP:  res = a - b;
			OP_JMP:  jump = 1'b1;
			OP_BRC: begin
				// Condition sits in the low two bits of the dst field
				case (word[25:24])
					2'd0:    jump = 1'b1;
					2'd1:    jump = exp_zero;
					2'd2:    jump = ~exp_zero;
					default: jump = exp_neg;
				endcase
			end
			OP_HALT: done = 1'b1;
			default: ;
		endcase
		if (sets_flags) begin
			exp_zero = (res == '0);
			exp_neg  = res[31];
		end
		if (writes) begin
			regs[word[27:24]] = res;
			exp_dst.push_back(word[27:24]);
			exp_data.push_back(res);
		end
		pc = jump ? int'(word[15:0]) : pc + 1;
	end
endfunction

`endif

// File: test/tb_scalar_unit.sv
// Testbench for the scalar unit; random programs are stored, run with run toggling and checked
`timescale 1ns/10ps

module tb_scalar_unit import scalar_pkg::*; ();

	localparam int IMEM_DEPTH      = 64;
	localparam int CLK_PERIOD      = 20;
	localparam int NUM_PROGS       = 20;
	localparam int MAX_LEN         = 41;
	localparam int DRAIN_CYCLES    = 6;
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (MAX_LEN * 10 + 200);

	logic                          clock;
	logic                          reset;
	logic                          run;
	logic                          st_req;
	logic [$clog2(IMEM_DEPTH)-1:0] st_addr;
	instr_u                        st_instr;
	logic                          st_ack;
	wb_t                           wb;
	status_t                       status;
	logic                          term;

	`include "scalar_model.svh"

	scalar_unit #(.IMEM_DEPTH(IMEM_DEPTH)) i_scalar_unit (
		.clock, .reset, .run, .st_req, .st_addr, .st_instr, .st_ack, .wb, .status, .term
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////
	// Failure handling

	task automatic abort_run();
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: actual %h expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all programs finished");
		abort_run();
	end

	////////////////////
	// Stimulus

	function automatic logic [31:0] encode_word(opcode_e op, logic [3:0] f1, logic [3:0] f2,
			logic [3:0] f3, logic [15:0] imm);
		return {op, f1, f2, f3, imm};
	endfunction

	// Run stays high during reset so that wb and term are not masked
	task automatic apply_reset();
		@(posedge clock);
		#2;
		reset  = 1'b1;
		run    = 1'b1;
		st_req = 1'b0;
		@(posedge clock);
		@(negedge clock);
		check_value("st_ack", 32'(st_ack), 32'(0));
		check_value("wb.valid", 32'(wb.valid), 32'(0));
		check_value("term", 32'(term), 32'(0));
		@(posedge clock);
		#2;
		reset = 1'b0;
		run   = 1'b0;
	endtask

	// Branch targets point forward only so every program reaches its HALT
	task automatic generate_program();
		int          n;
		int          kind;
		int          tgt;
		logic [3:0]  dst;
		logic [3:0]  s1;
		logic [3:0]  s2;
		logic [1:0]  cond;
		logic [15:0] imm;
		n = 10 + int'($urandom % 31);
		for (int i = 0; i < n; i++) begin
			dst  = 4'($urandom);
			s1   = 4'($urandom);
			s2   = 4'($urandom);
			cond = 2'($urandom);
			imm  = ($urandom % 2 == 0) ? 16'($urandom) : 16'($urandom % 5) - 16'd2;
			tgt  = i + 1 + int'($urandom % (n - i));
			kind = int'($urandom % 12);
			case (kind)
				0:       prog[i] = encode_word(OP_ADD, dst, s1, s2, 16'h0);
				1:       prog[i] = encode_word(OP_SUB, dst, s1, s2, 16'h0);
				2:       prog[i] = encode_word(OP_AND, dst, s1, s2, 16'h0);
				3:       prog[i] = encode_word(OP_OR, dst, s1, s2, 16'h0);
				4:       prog[i] = encode_word(OP_XOR, dst, s1, s2, 16'h0);
				5:       prog[i] = encode_word(OP_ADDI, dst, s1, 4'h0, imm);
				6, 7:    prog[i] = encode_word(OP_MOVI, dst, 4'h0, 4'h0, imm);
				8:       prog[i] = encode_word(OP_CMP, 4'h0, s1, s2, 16'h0);
				9, 10:   prog[i] = encode_word(OP_BRC, {dst[3:2], cond}, 4'h0, 4'h0, 16'(tgt));
				default: prog[i] = encode_word(OP_JMP, 4'h0, 4'h0, 4'h0, 16'(tgt));
			endcase
		end
		prog[n]  = encode_word(OP_HALT, 4'h0, 4'h0, 4'h0, 16'h0);
		prog_len = n + 1;
		// Unused words are NOPs tagged with their own address
		for (int a = prog_len; a < IMEM_DEPTH; a++) begin
			prog[a] = encode_word(OP_NOP, 4'h0, 4'h0, 4'h0, 16'(a));
		end
	endtask

	// Back-to-back stores with the ack one cycle behind each request
	task automatic load_program();
		logic prev_req;
		prev_req = 1'b0;
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			@(posedge clock);
			#2;
			st_req   = 1'b1;
			st_addr  = 6'(a);
			st_instr = prog[a];
			@(negedge clock);
			check_value("st_ack", 32'(st_ack), 32'(prev_req));
			prev_req = 1'b1;
		end
		@(posedge clock);
		#2;
		st_req = 1'b0;
		@(negedge clock);
		check_value("st_ack", 32'(st_ack), 32'(1));
		@(negedge clock);
		check_value("st_ack", 32'(st_ack), 32'(0));
	endtask

	task automatic run_program();
		int wb_idx;
		int low_left;
		bit seen_term;
		wb_idx    = 0;
		low_left  = 0;
		seen_term = 1'b0;
		while (!seen_term) begin
			@(posedge clock);
			#2;
			if (low_left > 0) begin
				run = 1'b0;
				low_left--;
			end else begin
				run = 1'b1;
				if ($urandom % 8 == 0) begin
					low_left = 1 + int'($urandom % 4);
				end
			end
			@(negedge clock);
			if (wb.valid) begin
				if (wb_idx >= exp_dst.size()) begin
					$display("Write-back beyond the end of the expected list");
					abort_run();
				end
				check_value("wb.dst", 32'(wb.dst), 32'(exp_dst[wb_idx]));
				check_value("wb.data", wb.data, exp_data[wb_idx]);
				wb_idx++;
			end
			if (term) begin
				seen_term = 1'b1;
				check_value("wb count", 32'(wb_idx), 32'(exp_dst.size()));
			end
		end
		// Nothing may follow the end of the program
		repeat (DRAIN_CYCLES) begin
			@(posedge clock);
			#2;
			run = 1'b1;
			@(negedge clock);
			check_value("wb.valid", 32'(wb.valid), 32'(0));
			check_value("term", 32'(term), 32'(0));
		end
		check_value("status.zero", 32'(status.zero), 32'(exp_zero));
		check_value("status.neg", 32'(status.neg), 32'(exp_neg));
	endtask

	initial begin
		reset    = 1'b1;
		run      = 1'b0;
		st_req   = 1'b0;
		st_addr  = '0;
		st_instr = '0;
		void'($urandom(29460));
		for (int p = 0; p < NUM_PROGS; p++) begin
			apply_reset();
			generate_program();
			model_execute();
			load_program();
			run_program();
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule
